/* rtl/fb_pkg.sv */
//==========================================================================
// Packet layout shared by the framebuffer blocks. Every packet is 52 bits
// with the symbol ID in the low byte, and only the low ID bits are decoded
//==========================================================================
package fb_pkg;

	// Width of one payload packet word as it arrives from the host
	localparam int PKT_BITS = 52;

	// The symbol ID field always sits at the bottom of the packet
	localparam int SYM_FIELD_BITS = 8;

	// Coordinates and dimensions are counted in units, not pixels
	localparam int COORD_BITS = 16;

	// One color channel, and the three channels packed red low to blue high
	localparam int COLOR_BITS = 4;
	localparam int COLOR_WORD_BITS = 3 * COLOR_BITS;

	// Grey level shown on every channel when the display is not drawing
	localparam logic [COLOR_BITS-1:0] DEFAULT_CHAN = COLOR_BITS'(5);

	// Program packet loads the attribute tables for one symbol ID
	typedef struct packed {
		logic [COLOR_WORD_BITS-1:0] color;
		logic [COORD_BITS-1:0]      width;
		logic [COORD_BITS-1:0]      height;
		logic [SYM_FIELD_BITS-1:0]  sym_id;
	} prog_pkt_t;

	// Draw packet places one symbol with its top left corner at a unit
	// The top bits are padding so that both views have the same width
	typedef struct packed {
		logic [PKT_BITS-2*COORD_BITS-SYM_FIELD_BITS-1:0] rsvd;
		logic [COORD_BITS-1:0]                          top;
		logic [COORD_BITS-1:0]                          left;
		logic [SYM_FIELD_BITS-1:0]                      sym_id;
	} draw_pkt_t;

	// The same word read either way, picked by the host's mode line
	typedef union packed {
		prog_pkt_t prog;
		draw_pkt_t draw;
	} pkt_word_t;

endpackage

/* rtl/attr_tables.sv */
//==========================================================================
// Symbol attribute tables. Dimensions are read without a clock; the color
// read is registered and forms stage 2 of the render pipe
//==========================================================================
`timescale 1ns/1ps

module attr_tables
	import fb_pkg::*;
#(
	parameter int SYM_ID_BITS = 4
) (
	input  logic                       i_clk,
	input  logic                       i_prog_we,
	input  pkt_word_t                  i_pkt,
	input  logic [SYM_ID_BITS-1:0]     i_dim_id,
	input  logic [SYM_ID_BITS-1:0]     i_color_id,
	output logic [COORD_BITS-1:0]      o_width,
	output logic [COORD_BITS-1:0]      o_height,
	output logic [COLOR_WORD_BITS-1:0] o_color
);

	localparam int NUM_SYMS = 1 << SYM_ID_BITS;

	// One entry per symbol ID in each table
	logic [COLOR_WORD_BITS-1:0] color_mem  [NUM_SYMS];
	logic [COORD_BITS-1:0]      width_mem  [NUM_SYMS];
	logic [COORD_BITS-1:0]      height_mem [NUM_SYMS];

	// Upper bits of the ID byte are ignored, so IDs alias modulo the table size
	logic [SYM_ID_BITS-1:0] wr_id;
	assign wr_id = i_pkt.prog.sym_id[SYM_ID_BITS-1:0];

	// A program packet updates color and both dimensions in one edge
	always_ff @(posedge i_clk) begin
		if (i_prog_we) begin
			color_mem[wr_id]  <= i_pkt.prog.color;
			width_mem[wr_id]  <= i_pkt.prog.width;
			height_mem[wr_id] <= i_pkt.prog.height;
		end
	end

	// The rasterizer looks up dimensions while it loads a command,
	// so these reads are combinational
	assign o_width  = width_mem[i_dim_id];
	assign o_height = height_mem[i_dim_id];

	// Color lookup follows the page read by one clock
	always_ff @(posedge i_clk) begin
		o_color <= color_mem[i_color_id];
	end

endmodule

/* rtl/draw_cmd_fifo.sv */
//==========================================================================
// Draw command FIFO with one slot kept open, so it holds 2^N-1 commands.
// A push while full overwrites the head slot and is lost
//==========================================================================
`timescale 1ns/1ps

module draw_cmd_fifo
	import fb_pkg::*;
#(
	parameter int FIFO_DEPTH_BITS = 3
) (
	input  logic      i_clk,
	input  logic      n_btn_rst,
	input  logic      i_push,
	input  pkt_word_t i_pkt,
	input  logic      i_pop,
	input  logic      i_flush,
	output pkt_word_t o_tail,
	output logic      o_empty,
	output logic      o_full
);

	localparam int DEPTH = 1 << FIFO_DEPTH_BITS;

	pkt_word_t                  cmd_mem [DEPTH];
	logic [FIFO_DEPTH_BITS-1:0] head;
	logic [FIFO_DEPTH_BITS-1:0] tail;
	logic [FIFO_DEPTH_BITS-1:0] next_head;

	// Pointers wrap naturally at the power of two depth
	assign next_head = head + 1'b1;
	assign o_full    = (next_head == tail);
	assign o_empty   = (head == tail);

	// The command at the tail is visible with no read latency
	assign o_tail = cmd_mem[tail];

	// The head slot is never part of the queue, so writing it while full is harmless
	always_ff @(posedge i_clk) begin
		if (i_push) begin
			cmd_mem[head] <= i_pkt;
		end
	end

	always_ff @(posedge i_clk or negedge n_btn_rst) begin
		if (!n_btn_rst) begin
			head <= '0;
			tail <= '0;
		end else begin
			if (i_push && !o_full) begin
				head <= next_head;
			end
			// Frame end drops everything pending and beats a pop in the same cycle
			if (i_flush) begin
				tail <= head;
			end else if (i_pop && !o_empty) begin
				tail <= tail + 1'b1;
			end
		end
	end

endmodule

/* rtl/sym_rasterizer.sv */
//==========================================================================
// Walks each symbol's unit rectangle, inclusive at both ends, one unit per
// clock. Units outside the grid take a cycle but are not written
//==========================================================================
`timescale 1ns/1ps

module sym_rasterizer
	import fb_pkg::*;
#(
	parameter int SYM_ID_BITS = 4,
	parameter int H_UNITS = 4,
	parameter int V_UNITS = 3,
	localparam int ADDR_BITS = $clog2(H_UNITS * V_UNITS)
) (
	input  logic                   i_clk,
	input  logic                   n_btn_rst,
	input  pkt_word_t              i_cmd,
	input  logic                   i_cmd_empty,
	input  logic                   i_abort,
	input  logic [COORD_BITS-1:0]  i_width,
	input  logic [COORD_BITS-1:0]  i_height,
	output logic                   o_pop,
	output logic                   o_wr_en,
	output logic [ADDR_BITS-1:0]   o_wr_addr,
	output logic [SYM_ID_BITS-1:0] o_wr_id,
	output logic                   o_idle
);

	// One extra bit keeps left plus width from wrapping back into the grid
	localparam logic [COORD_BITS:0]  H_LIMIT  = (COORD_BITS + 1)'(H_UNITS);
	localparam logic [COORD_BITS:0]  V_LIMIT  = (COORD_BITS + 1)'(V_UNITS);
	localparam logic [ADDR_BITS-1:0] H_STRIDE = ADDR_BITS'(H_UNITS);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_DRAW
	} rast_state_t;

	rast_state_t            state;
	logic [SYM_ID_BITS-1:0] cmd_id;
	logic [COORD_BITS:0]    left_x;
	logic [COORD_BITS:0]    right_x;
	logic [COORD_BITS:0]    bottom_y;
	logic [COORD_BITS:0]    cur_x;
	logic [COORD_BITS:0]    cur_y;
	logic                   row_end;
	logic                   last_unit;
	logic                   in_grid;

	assign row_end   = (cur_x == right_x);
	assign last_unit = row_end && (cur_y == bottom_y);
	assign in_grid   = (cur_x < H_LIMIT) && (cur_y < V_LIMIT);

	always_ff @(posedge i_clk or negedge n_btn_rst) begin
		if (!n_btn_rst) begin
			state <= ST_IDLE;
		end else if (i_abort) begin
			// Frame end abandons the symbol in progress
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (!i_cmd_empty) begin
						state <= ST_LOAD;
					end
				end
				ST_LOAD: state <= ST_DRAW;
				ST_DRAW: begin
					if (last_unit) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Corner and bounds are captured while the command still sits at the FIFO tail,
	// whose ID also drives the dimension lookup
	always_ff @(posedge i_clk) begin
		case (state)
			ST_LOAD: begin
				cmd_id   <= i_cmd.draw.sym_id[SYM_ID_BITS-1:0];
				left_x   <= {1'b0, i_cmd.draw.left};
				cur_x    <= {1'b0, i_cmd.draw.left};
				cur_y    <= {1'b0, i_cmd.draw.top};
				right_x  <= {1'b0, i_cmd.draw.left} + {1'b0, i_width};
				bottom_y <= {1'b0, i_cmd.draw.top} + {1'b0, i_height};
			end
			ST_DRAW: begin
				// Step along the row, then back to the left edge of the next row
				if (!row_end) begin
					cur_x <= cur_x + 1'b1;
				end else begin
					cur_x <= left_x;
					cur_y <= cur_y + 1'b1;
				end
			end
			default: ;
		endcase
	end

	// The command leaves the FIFO as it is latched
	assign o_pop  = (state == ST_LOAD);
	assign o_idle = (state == ST_IDLE);

	assign o_wr_en   = (state == ST_DRAW) && in_grid;
	assign o_wr_addr = cur_x[ADDR_BITS-1:0] + cur_y[ADDR_BITS-1:0] * H_STRIDE;
	assign o_wr_id   = cmd_id;

endmodule

/* rtl/page_store.sv */
//==========================================================================
// Two pages of unit IDs. Writes go to the back page; the front page is read
// registered and can be cleared at the same address in the same cycle
//==========================================================================
`timescale 1ns/1ps

module page_store #(
	parameter int SYM_ID_BITS = 4,
	parameter int H_UNITS = 4,
	parameter int V_UNITS = 3,
	localparam int ADDR_BITS = $clog2(H_UNITS * V_UNITS)
) (
	input  logic                   i_clk,
	input  logic                   n_btn_rst,
	input  logic                   i_flip,
	input  logic                   i_wr_en,
	input  logic [ADDR_BITS-1:0]   i_wr_addr,
	input  logic [SYM_ID_BITS-1:0] i_wr_id,
	input  logic [ADDR_BITS-1:0]   i_rd_addr,
	input  logic                   i_clear,
	output logic [SYM_ID_BITS-1:0] o_rd_id
);

	localparam int NUM_UNITS = H_UNITS * V_UNITS;

	// Index of the page being displayed while the other one is drawn
	logic front_sel;
	// Front select as it was when the current read data was fetched
	logic rd_sel;
	// Registered read word of each page
	logic [SYM_ID_BITS-1:0] page_rd [2];

	always_ff @(posedge i_clk or negedge n_btn_rst) begin
		if (!n_btn_rst) begin
			front_sel <= 1'b0;
			rd_sel    <= 1'b0;
		end else begin
			rd_sel <= front_sel;
			if (i_flip) begin
				front_sel <= ~front_sel;
			end
		end
	end

	for (genvar p = 0; p < 2; p++) begin : g_page
		logic [SYM_ID_BITS-1:0] unit_mem [NUM_UNITS];
		logic                   is_front;

		assign is_front = (front_sel == 1'(p));

		// Each page has one write port, used for clears while in front
		// and for rasterizer writes while in back
		always_ff @(posedge i_clk) begin
			if (is_front) begin
				if (i_clear) begin
					unit_mem[i_rd_addr] <= '0;
				end
			end else if (i_wr_en) begin
				unit_mem[i_wr_addr] <= i_wr_id;
			end
		end

		// Old data comes out when a clear hits the same address
		always_ff @(posedge i_clk) begin
			page_rd[p] <= unit_mem[i_rd_addr];
		end
	end

	assign o_rd_id = rd_sel ? page_rd[1] : page_rd[0];

endmodule

/* rtl/pixel_colorer.sv */
//==========================================================================
// Render path, 3 clocks from pixel position to color with no stall. The
// position is in active-area pixels and must fall inside the unit grid
//==========================================================================
`timescale 1ns/1ps

module pixel_colorer
	import fb_pkg::*;
#(
	parameter int SYM_ID_BITS = 4,
	parameter int H_UNITS = 4,
	parameter int V_UNITS = 3,
	parameter int UNIT_PIX = 4,
	localparam int ADDR_BITS = $clog2(H_UNITS * V_UNITS)
) (
	input  logic                       i_clk,
	input  logic                       n_btn_rst,
	input  logic                       i_draw_en,
	input  logic [COORD_BITS-1:0]      i_sx,
	input  logic [COORD_BITS-1:0]      i_sy,
	input  logic [SYM_ID_BITS-1:0]     i_rd_id,
	input  logic [COLOR_WORD_BITS-1:0] i_color,
	output logic [ADDR_BITS-1:0]       o_rd_addr,
	output logic                       o_clear,
	output logic [SYM_ID_BITS-1:0]     o_color_id,
	output logic [COLOR_BITS-1:0]      o_color_r,
	output logic [COLOR_BITS-1:0]      o_color_g,
	output logic [COLOR_BITS-1:0]      o_color_b
);

	localparam logic [COORD_BITS-1:0] UNIT_W   = COORD_BITS'(UNIT_PIX);
	localparam logic [ADDR_BITS-1:0]  H_STRIDE = ADDR_BITS'(H_UNITS);

	logic [COORD_BITS-1:0] unit_x;
	logic [COORD_BITS-1:0] unit_y;
	logic                  last_x;
	logic                  last_y;
	// Draw enable delayed to line up with the page read and the color read
	logic                  en_q1;
	logic                  en_q2;

	assign unit_x = i_sx / UNIT_W;
	assign unit_y = i_sy / UNIT_W;
	assign o_rd_addr = unit_x[ADDR_BITS-1:0] + unit_y[ADDR_BITS-1:0] * H_STRIDE;

	// The bottom right pixel of a unit is the last one to need its ID
	assign last_x  = ((i_sx % UNIT_W) == (UNIT_W - 1'b1));
	assign last_y  = ((i_sy % UNIT_W) == (UNIT_W - 1'b1));
	assign o_clear = i_draw_en && last_x && last_y;

	// Stage 1 output from the page store goes straight to the color table
	assign o_color_id = i_rd_id;

	always_ff @(posedge i_clk or negedge n_btn_rst) begin
		if (!n_btn_rst) begin
			en_q1     <= 1'b0;
			en_q2     <= 1'b0;
			o_color_r <= '0;
			o_color_g <= '0;
			o_color_b <= '0;
		end else begin
			en_q1 <= i_draw_en;
			en_q2 <= en_q1;
			// Stage 3 takes the table color when drawing and flat grey otherwise
			if (en_q2) begin
				o_color_r <= i_color[COLOR_BITS-1:0];
				o_color_g <= i_color[2*COLOR_BITS-1:COLOR_BITS];
				o_color_b <= i_color[3*COLOR_BITS-1:2*COLOR_BITS];
			end else begin
				o_color_r <= DEFAULT_CHAN;
				o_color_g <= DEFAULT_CHAN;
				o_color_b <= DEFAULT_CHAN;
			end
		end
	end

endmodule

/* rtl/framebuf_manager.sv */
//==========================================================================
// Symbol framebuffer top. Host must respect o_cmd_full, and i_frame_end is
// a one-cycle pulse that swaps pages and drops pending draw commands
//==========================================================================
`timescale 1ns/1ps

module framebuf_manager
	import fb_pkg::*;
#(
	parameter int SYM_ID_BITS = 4,
	parameter int FIFO_DEPTH_BITS = 3,
	parameter int H_UNITS = 4,
	parameter int V_UNITS = 3,
	parameter int UNIT_PIX = 4
) (
	input  logic                  i_clk,
	input  logic                  n_btn_rst,
	input  logic                  i_sym_mode,
	input  logic                  i_pkt_valid,
	input  pkt_word_t             i_pkt,
	input  logic                  i_frame_end,
	input  logic                  i_draw_en,
	input  logic [COORD_BITS-1:0] i_sx,
	input  logic [COORD_BITS-1:0] i_sy,
	output logic [COLOR_BITS-1:0] o_color_r,
	output logic [COLOR_BITS-1:0] o_color_g,
	output logic [COLOR_BITS-1:0] o_color_b,
	output logic                  o_cmd_full,
	output logic                  o_draw_idle
);

	localparam int ADDR_BITS = $clog2(H_UNITS * V_UNITS);

	logic                       prog_we;
	logic                       draw_we;
	pkt_word_t                  fifo_tail;
	logic                       fifo_empty;
	logic                       fifo_pop;
	logic [COORD_BITS-1:0]      sym_width;
	logic [COORD_BITS-1:0]      sym_height;
	logic                       wr_en;
	logic [ADDR_BITS-1:0]       wr_addr;
	logic [SYM_ID_BITS-1:0]     wr_id;
	logic                       rast_idle;
	logic [ADDR_BITS-1:0]       rd_addr;
	logic                       rd_clear;
	logic [SYM_ID_BITS-1:0]     rd_id;
	logic [SYM_ID_BITS-1:0]     color_id;
	logic [COLOR_WORD_BITS-1:0] color_word;

	// Mode low means program packet, high means draw packet
	assign prog_we = i_pkt_valid && !i_sym_mode;
	assign draw_we = i_pkt_valid && i_sym_mode;

	// Drawing is finished once nothing is queued and nothing is in progress
	assign o_draw_idle = fifo_empty && rast_idle;

	attr_tables #(.SYM_ID_BITS(SYM_ID_BITS)) u_attr (
		.i_clk(i_clk), .i_prog_we(prog_we), .i_pkt(i_pkt),
		.i_dim_id(fifo_tail.draw.sym_id[SYM_ID_BITS-1:0]), .i_color_id(color_id),
		.o_width(sym_width), .o_height(sym_height), .o_color(color_word)
	);

	draw_cmd_fifo #(.FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)) u_fifo (
		.i_clk(i_clk), .n_btn_rst(n_btn_rst), .i_push(draw_we), .i_pkt(i_pkt),
		.i_pop(fifo_pop), .i_flush(i_frame_end),
		.o_tail(fifo_tail), .o_empty(fifo_empty), .o_full(o_cmd_full)
	);

	sym_rasterizer #(.SYM_ID_BITS(SYM_ID_BITS), .H_UNITS(H_UNITS), .V_UNITS(V_UNITS)) u_rast (
		.i_clk(i_clk), .n_btn_rst(n_btn_rst), .i_cmd(fifo_tail), .i_cmd_empty(fifo_empty),
		.i_abort(i_frame_end), .i_width(sym_width), .i_height(sym_height),
		.o_pop(fifo_pop), .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_id(wr_id),
		.o_idle(rast_idle)
	);

	page_store #(.SYM_ID_BITS(SYM_ID_BITS), .H_UNITS(H_UNITS), .V_UNITS(V_UNITS)) u_pages (
		.i_clk(i_clk), .n_btn_rst(n_btn_rst), .i_flip(i_frame_end),
		.i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_id(wr_id),
		.i_rd_addr(rd_addr), .i_clear(rd_clear), .o_rd_id(rd_id)
	);

	pixel_colorer #(
		.SYM_ID_BITS(SYM_ID_BITS), .H_UNITS(H_UNITS), .V_UNITS(V_UNITS), .UNIT_PIX(UNIT_PIX)
	) u_colorer (
		.i_clk(i_clk), .n_btn_rst(n_btn_rst), .i_draw_en(i_draw_en),
		.i_sx(i_sx), .i_sy(i_sy), .i_rd_id(rd_id), .i_color(color_word),
		.o_rd_addr(rd_addr), .o_clear(rd_clear), .o_color_id(color_id),
		.o_color_r(o_color_r), .o_color_g(o_color_g), .o_color_b(o_color_b)
	);

endmodule

/* sim/tb_framebuf_manager.sv */
//==========================================================================
// Testbench for the framebuffer at default parameters (4x3 units of 4x4
// pixels). A model of both pages predicts every pixel of each scan
//==========================================================================
`timescale 1ns/1ps

module tb_framebuf_manager
	import fb_pkg::*;
();

	// Mirror of the DUT defaults, used only by the reference model
	localparam int H_UNITS    = 4;
	localparam int V_UNITS    = 3;
	localparam int UNIT_PIX   = 4;
	localparam int NUM_UNITS  = H_UNITS * V_UNITS;
	localparam int W_PIX      = H_UNITS * UNIT_PIX;
	localparam int NUM_PIX    = W_PIX * V_UNITS * UNIT_PIX;
	localparam int NUM_STIM   = 12;
	localparam int WAIT_LIMIT = 1000;

	logic                  i_clk;
	logic                  n_btn_rst;
	logic                  i_sym_mode;
	logic                  i_pkt_valid;
	pkt_word_t             i_pkt;
	logic                  i_frame_end;
	logic                  i_draw_en;
	logic [COORD_BITS-1:0] i_sx;
	logic [COORD_BITS-1:0] i_sy;
	logic [COLOR_BITS-1:0] o_color_r;
	logic [COLOR_BITS-1:0] o_color_g;
	logic [COLOR_BITS-1:0] o_color_b;
	logic                  o_cmd_full;
	logic                  o_draw_idle;

	// Reference model of the attribute tables and of both pages
	logic [COLOR_WORD_BITS-1:0] model_color [16];
	int                         model_w [16];
	int                         model_h [16];
	int                         model_page [2][NUM_UNITS];
	int                         front;
	// Stimulus rows hold kind (0 program, 1 draw), ID, then width/height or left/top
	int                         stim_tab [NUM_STIM][4];
	integer                     seed;
	int                         checks;
	int                         errors;
	int                         errors_before;
	bit                         saw_full;

	framebuf_manager UUT (
		.i_clk(i_clk), .n_btn_rst(n_btn_rst), .i_sym_mode(i_sym_mode),
		.i_pkt_valid(i_pkt_valid), .i_pkt(i_pkt), .i_frame_end(i_frame_end),
		.i_draw_en(i_draw_en), .i_sx(i_sx), .i_sy(i_sy),
		.o_color_r(o_color_r), .o_color_g(o_color_g), .o_color_b(o_color_b),
		.o_cmd_full(o_cmd_full), .o_draw_idle(o_draw_idle)
	);

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	task automatic set_entry(input int idx, input int kind, input int id, input int a,
		input int b);
		stim_tab[idx][0] = kind;
		stim_tab[idx][1] = id;
		stim_tab[idx][2] = a;
		stim_tab[idx][3] = b;
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] time %0t: %s is %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic abort_run(input string why);
		$display("Run stopped: %s", why);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic end_test(input int num, input string name);
		$display("Test %0d (%s) finished with %0d errors", num, name, errors - errors_before);
		errors_before = errors;
	endtask

	// Every task below starts and ends 1 ns after a rising edge
	task automatic send_program(input int id, input int w, input int h);
		logic [COLOR_WORD_BITS-1:0] color;
		color = COLOR_WORD_BITS'($random(seed));
		i_pkt = '0;
		i_pkt.prog.color  = color;
		i_pkt.prog.width  = COORD_BITS'(w);
		i_pkt.prog.height = COORD_BITS'(h);
		i_pkt.prog.sym_id = SYM_FIELD_BITS'(id);
		i_sym_mode  = 1'b0;
		i_pkt_valid = 1'b1;
		@(posedge i_clk);
		#1;
		i_pkt_valid = 1'b0;
		model_color[id] = color;
		model_w[id] = w;
		model_h[id] = h;
	endtask

	// Draws land on the back page, inclusive of left+width and top+height,
	// and units past the grid edge are skipped
	task automatic model_draw(input int id, input int left, input int top);
		int back;
		back = 1 - front;
		for (int y = top; y <= top + model_h[id]; y++) begin
			for (int x = left; x <= left + model_w[id]; x++) begin
				if (x < H_UNITS && y < V_UNITS) begin
					model_page[back][x + y * H_UNITS] = id;
				end
			end
		end
	endtask

	task automatic send_draw(input int id, input int left, input int top);
		int n;
		n = 0;
		// Only offer a packet while the FIFO has room
		while (o_cmd_full) begin
			saw_full = 1'b1;
			@(posedge i_clk);
			#1;
			n++;
			if (n > WAIT_LIMIT) begin
				abort_run("FIFO stayed full and a draw packet could not be sent");
			end
		end
		i_pkt = '0;
		i_pkt.draw.left   = COORD_BITS'(left);
		i_pkt.draw.top    = COORD_BITS'(top);
		i_pkt.draw.sym_id = SYM_FIELD_BITS'(id);
		i_sym_mode  = 1'b1;
		i_pkt_valid = 1'b1;
		@(posedge i_clk);
		#1;
		i_pkt_valid = 1'b0;
		model_draw(id, left, top);
	endtask

	task automatic apply_entries(input int first, input int last);
		for (int e = first; e <= last; e++) begin
			if (stim_tab[e][0] == 0) begin
				send_program(stim_tab[e][1], stim_tab[e][2], stim_tab[e][3]);
			end else begin
				send_draw(stim_tab[e][1], stim_tab[e][2], stim_tab[e][3]);
			end
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (!o_draw_idle) begin
			@(posedge i_clk);
			#1;
			n++;
			if (n > WAIT_LIMIT) begin
				abort_run("draw engine did not return to idle in time");
			end
		end
	endtask

	task automatic flip_page();
		i_frame_end = 1'b1;
		@(posedge i_clk);
		#1;
		i_frame_end = 1'b0;
		front = 1 - front;
	endtask

	// One pixel per clock in raster order, each result checked 3 clocks later
	task automatic scan_frame(input bit check);
		logic [COLOR_WORD_BITS-1:0] exp_word [NUM_PIX];
		int unit;
		for (int p = 0; p < NUM_PIX; p++) begin
			unit = (p % W_PIX) / UNIT_PIX + ((p / W_PIX) / UNIT_PIX) * H_UNITS;
			exp_word[p] = model_color[model_page[front][unit]];
		end
		for (int i = 0; i < NUM_PIX + 2; i++) begin
			if (i < NUM_PIX) begin
				i_sx = COORD_BITS'(i % W_PIX);
				i_sy = COORD_BITS'(i / W_PIX);
				i_draw_en = 1'b1;
			end else begin
				i_draw_en = 1'b0;
			end
			@(posedge i_clk);
			#1;
			if (check && i >= 2) begin
				check_value("o_color_r", o_color_r, exp_word[i-2][3:0]);
				check_value("o_color_g", o_color_g, exp_word[i-2][7:4]);
				check_value("o_color_b", o_color_b, exp_word[i-2][11:8]);
			end
		end
		// Each unit's last pixel was read, so the whole front page is now ID 0
		for (int u = 0; u < NUM_UNITS; u++) begin
			model_page[front][u] = 0;
		end
	endtask

	initial begin
		seed          = 58230;
		checks        = 0;
		errors        = 0;
		errors_before = 0;
		front         = 0;
		saw_full      = 1'b0;
		n_btn_rst     = 1'b0;
		i_sym_mode    = 1'b0;
		i_pkt_valid   = 1'b0;
		i_pkt         = '0;
		i_frame_end   = 1'b0;
		i_draw_en     = 1'b0;
		i_sx          = '0;
		i_sy          = '0;

		// Symbols 1 to 5, then overlapping draws, then one draw past the edges
		set_entry(0, 0, 1, 0, 0);
		set_entry(1, 0, 2, 1, 0);
		set_entry(2, 0, 3, 1, 1);
		set_entry(3, 0, 4, 3, 2);
		set_entry(4, 0, 5, 2, 2);
		set_entry(5, 1, 4, 0, 0);
		set_entry(6, 1, 3, 1, 0);
		set_entry(7, 1, 1, 0, 2);
		set_entry(8, 1, 2, 2, 2);
		set_entry(9, 1, 1, 3, 0);
		set_entry(10, 1, 3, 2, 1);
		set_entry(11, 1, 5, 3, 1);

		repeat (2) @(posedge i_clk);
		#1;
		n_btn_rst = 1'b1;

		check_value("o_color_r", o_color_r, 0);
		check_value("o_color_g", o_color_g, 0);
		check_value("o_color_b", o_color_b, 0);
		check_value("o_draw_idle", o_draw_idle, 1);
		check_value("o_cmd_full", o_cmd_full, 0);
		end_test(1, "reset values");

		// The first two scans clear the unknown contents of both pages
		send_program(0, 0, 0);
		scan_frame(1'b0);
		flip_page();
		scan_frame(1'b0);
		flip_page();
		scan_frame(1'b1);
		end_test(2, "background setup");

		apply_entries(0, 10);
		wait_idle();
		flip_page();
		scan_frame(1'b1);
		end_test(3, "table drawing");

		// A wrap past the right edge would show up in the next row
		apply_entries(11, 11);
		wait_idle();
		flip_page();
		scan_frame(1'b1);
		flip_page();
		scan_frame(1'b1);
		end_test(4, "clipping and clear");

		for (int i = 0; i < 8; i++) begin
			i_sx = COORD_BITS'(3 + 4 * (i % H_UNITS));
			i_sy = COORD_BITS'(3 + 4 * (i % V_UNITS));
			i_draw_en = 1'b0;
			@(posedge i_clk);
			#1;
			if (i >= 2) begin
				check_value("o_color_r", o_color_r, DEFAULT_CHAN);
				check_value("o_color_g", o_color_g, DEFAULT_CHAN);
				check_value("o_color_b", o_color_b, DEFAULT_CHAN);
			end
		end
		end_test(5, "draw enable low");

		saw_full = 1'b0;
		for (int k = 0; k < 16; k++) begin
			send_draw((k % 2 == 0) ? 4 : 3, k % H_UNITS, k % V_UNITS);
		end
		checks++;
		assert (saw_full) else begin
			$display("o_cmd_full never rose while draw packets were sent every cycle");
			errors++;
		end
		wait_idle();
		flip_page();
		scan_frame(1'b1);
		end_test(6, "back-pressure");

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* framebuf_manager.f */
rtl/fb_pkg.sv
rtl/attr_tables.sv
rtl/draw_cmd_fifo.sv
rtl/sym_rasterizer.sv
rtl/page_store.sv
rtl/pixel_colorer.sv
rtl/framebuf_manager.sv
sim/tb_framebuf_manager.sv
